// File: project.f
+incdir+source
source/gpu_types_pkg.sv
source/divergence_pkg.sv
source/branch_predicate_split.sv
source/ipdom_stack.sv
source/split_join.sv
source/warp_mask_table.sv
source/divergence_unit.sv
tb/divergence_unit_tb.sv

// File: source/branch_predicate_split.sv
// Branch predicate split
`default_nettype none

module branch_predicate_split (
    input  wire divergence_pkg::cmd_t    cmd,
    input  wire gpu_types_pkg::tmask_t   cur_tmask,
    output divergence_pkg::split_t       split
);

    import gpu_types_pkg::*;

    tmask_t then_tmask;
    tmask_t else_tmask;
    logic   has_then;
    logic   has_else;

    // Only threads that are active right now take part in the branch
    assign then_tmask = cur_tmask & cmd.pred;
    assign else_tmask = cur_tmask & ~cmd.pred;

    assign has_then = |then_tmask;
    assign has_else = |else_tmask;

    always_comb begin
        split.valid      = cmd.valid && cmd.is_split;
        // The warp diverges only when both sides keep at least one thread
        split.is_dvg     = has_then && has_else;
        split.then_tmask = then_tmask;
        split.else_tmask = else_tmask;
        split.next_pc    = cmd.else_pc;
    end

endmodule

`default_nettype wire

// File: source/divergence_defs.svh
// Divergence unit sizes
`ifndef DIVERGENCE_DEFS_SVH
`define DIVERGENCE_DEFS_SVH

// Number of warps tracked by the unit
`define NUM_WARPS 4

// Threads per warp, one mask bit each
`define NUM_THREADS 4

// Program counter width
`define PC_BITS 16

// Entries per warp stack, enough for NUM_THREADS-1 nested levels
`define DV_STACK_SIZE 4

// Every warp starts here after reset
`define RESET_PC 16'h0100

`endif

// File: source/divergence_pkg.sv
// Divergence command and result types
`default_nettype none

package divergence_pkg;

    import gpu_types_pkg::*;

    // Command from the issue stage, exactly one of is_split or is_join is set
    typedef struct packed {
        logic   valid;
        logic   is_split;
        logic   is_join;
        wid_t   wid;
        tmask_t pred;
        pc_t    else_pc;
        sptr_t  stack_ptr;
    } cmd_t;

    // Outcome of evaluating a branch predicate against the active mask
    typedef struct packed {
        logic   valid;
        logic   is_dvg;
        tmask_t then_tmask;
        tmask_t else_tmask;
        pc_t    next_pc;
    } split_t;

    // Join request, stack_ptr is the depth the warp saw at its split
    typedef struct packed {
        logic   valid;
        tmask_t tmask;
        sptr_t  stack_ptr;
    } join_t;

    // Registered join outcome, applied to the warp table one cycle later
    typedef struct packed {
        logic   valid;
        wid_t   wid;
        logic   is_dvg;
        logic   is_else;
        tmask_t tmask;
        pc_t    pc;
    } join_res_t;

endpackage

`default_nettype wire

// File: source/divergence_unit.sv
// Thread divergence unit
`default_nettype none

module divergence_unit (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire divergence_pkg::cmd_t        cmd,
    input  wire gpu_types_pkg::wid_t         query_wid,
    input  wire gpu_types_pkg::wid_t         stack_wid,
    output divergence_pkg::join_res_t        join_res,
    output gpu_types_pkg::tmask_t            warp_tmask,
    output gpu_types_pkg::pc_t               warp_pc,
    output gpu_types_pkg::sptr_t             stack_ptr
);

    import gpu_types_pkg::*;
    import divergence_pkg::*;

    tmask_t cur_tmask;
    split_t split;
    join_t  sjoin;

    // The join carries the active mask so the else side can be derived
    assign sjoin = '{
        valid:     cmd.valid && cmd.is_join,
        tmask:     cur_tmask,
        stack_ptr: cmd.stack_ptr
    };

    warp_mask_table u_warp_mask_table (
        .clk        (clk),
        .rst_n      (rst_n),
        .rd_wid     (cmd.wid),
        .rd_tmask   (cur_tmask),
        .split_wid  (cmd.wid),
        .split      (split),
        .join_res   (join_res),
        .query_wid  (query_wid),
        .warp_tmask (warp_tmask),
        .warp_pc    (warp_pc)
    );

    branch_predicate_split u_branch_predicate_split (
        .cmd       (cmd),
        .cur_tmask (cur_tmask),
        .split     (split)
    );

    split_join u_split_join (
        .clk       (clk),
        .rst_n     (rst_n),
        .wid       (cmd.wid),
        .split     (split),
        .sjoin     (sjoin),
        .stack_wid (stack_wid),
        .join_res  (join_res),
        .stack_ptr (stack_ptr)
    );

endmodule

`default_nettype wire

// File: source/gpu_types_pkg.sv
// GPU core vector types
`default_nettype none

`include "divergence_defs.svh"

package gpu_types_pkg;

    // Index of a warp
    typedef logic [$clog2(`NUM_WARPS)-1:0] wid_t;

    // One bit per thread, set when the thread is active
    typedef logic [`NUM_THREADS-1:0] tmask_t;

    // Program counter
    typedef logic [`PC_BITS-1:0] pc_t;

    // Stack depth, counts from empty up to a full stack
    typedef logic [$clog2(`DV_STACK_SIZE + 1)-1:0] sptr_t;

endpackage

`default_nettype wire

// File: source/ipdom_stack.sv
// Per-warp IPDOM stacks
`default_nettype none

`include "divergence_defs.svh"

module ipdom_stack (
    input  wire                                        clk,
    input  wire                                        rst_n,
    input  wire gpu_types_pkg::wid_t                   wid,
    input  wire                                        push,
    input  wire                                        pop,
    input  wire gpu_types_pkg::tmask_t                 d_tmask,
    input  wire gpu_types_pkg::pc_t                    d_pc,
    input  wire gpu_types_pkg::sptr_t                  rd_ptr,
    output gpu_types_pkg::tmask_t                      q_tmask,
    output gpu_types_pkg::pc_t                         q_pc,
    output logic                                       q_visited,
    output gpu_types_pkg::sptr_t [`NUM_WARPS-1:0]      wr_ptr
);

    import gpu_types_pkg::*;

    // Entry storage, one row of DV_STACK_SIZE entries per warp
    tmask_t tmask_mem [`NUM_WARPS][`DV_STACK_SIZE];
    pc_t    pc_mem    [`NUM_WARPS][`DV_STACK_SIZE];

    // Set once the else side of an entry has been started
    logic [`NUM_WARPS-1:0][`DV_STACK_SIZE-1:0] visited;

    logic [$clog2(`DV_STACK_SIZE)-1:0] wr_idx;
    logic [$clog2(`DV_STACK_SIZE)-1:0] rd_idx;
    sptr_t                             cur_ptr;

    assign cur_ptr = wr_ptr[wid];

    // Only the low bits address an entry, overflow is not handled
    assign wr_idx = cur_ptr[$clog2(`DV_STACK_SIZE)-1:0];
    assign rd_idx = rd_ptr[$clog2(`DV_STACK_SIZE)-1:0];

    always_ff @(posedge clk) begin
        if (push) begin
            tmask_mem[wid][wr_idx] <= d_tmask;
            pc_mem[wid][wr_idx]    <= d_pc;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            visited <= '0;
        end else if (push) begin
            visited[wid][wr_idx] <= 1'b0;
            wr_ptr[wid]          <= cur_ptr + 1'b1;
        end else if (pop) begin
            // The first pop starts the else path and keeps the entry
            if (visited[wid][rd_idx]) begin
                wr_ptr[wid] <= cur_ptr - 1'b1;
            end else begin
                visited[wid][rd_idx] <= 1'b1;
            end
        end
    end

    assign q_tmask   = tmask_mem[wid][rd_idx];
    assign q_pc      = pc_mem[wid][rd_idx];
    assign q_visited = visited[wid][rd_idx];

endmodule

`default_nettype wire

// File: source/split_join.sv
// Split and join control
`default_nettype none

`include "divergence_defs.svh"

module split_join (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire gpu_types_pkg::wid_t         wid,
    input  wire divergence_pkg::split_t      split,
    input  wire divergence_pkg::join_t       sjoin,
    input  wire gpu_types_pkg::wid_t         stack_wid,
    output divergence_pkg::join_res_t        join_res,
    output gpu_types_pkg::sptr_t             stack_ptr
);

    import gpu_types_pkg::*;
    import divergence_pkg::*;

    sptr_t [`NUM_WARPS-1:0] wr_ptr;
    sptr_t                  top_ptr;
    tmask_t                 q_tmask;
    pc_t                    q_pc;
    logic                   q_visited;
    logic                   join_dvg;
    join_res_t              res_n;
    join_res_t              res_q;
    logic                   res_valid;

    // A join is divergent while the warp is deeper than it was at its split
    assign join_dvg = sjoin.valid && (sjoin.stack_ptr != wr_ptr[wid]);
    assign top_ptr  = wr_ptr[wid] - 1'b1;

    ipdom_stack u_ipdom_stack (
        .clk       (clk),
        .rst_n     (rst_n),
        .wid       (wid),
        .push      (split.valid && split.is_dvg),
        .pop       (join_dvg),
        .d_tmask   (split.then_tmask | split.else_tmask),
        .d_pc      (split.next_pc),
        .rd_ptr    (top_ptr),
        .q_tmask   (q_tmask),
        .q_pc      (q_pc),
        .q_visited (q_visited),
        .wr_ptr    (wr_ptr)
    );

    always_comb begin
        res_n.valid   = sjoin.valid;
        res_n.wid     = wid;
        res_n.is_dvg  = join_dvg;
        res_n.is_else = join_dvg && !q_visited;
        res_n.pc      = join_dvg ? q_pc : '0;
        if (!join_dvg) begin
            res_n.tmask = sjoin.tmask;
        end else if (q_visited) begin
            // Both sides are done, bring back the mask from before the split
            res_n.tmask = q_tmask;
        end else begin
            res_n.tmask = q_tmask & ~sjoin.tmask;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= res_n.valid;
        end
    end

    always_ff @(posedge clk) begin
        res_q <= res_n;
    end

    always_comb begin
        join_res       = res_q;
        join_res.valid = res_valid;
    end

    assign stack_ptr = wr_ptr[stack_wid];

endmodule

`default_nettype wire

// File: source/warp_mask_table.sv
// Warp mask and PC table
`default_nettype none

`include "divergence_defs.svh"

module warp_mask_table (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire gpu_types_pkg::wid_t         rd_wid,
    output gpu_types_pkg::tmask_t            rd_tmask,
    input  wire gpu_types_pkg::wid_t         split_wid,
    input  wire divergence_pkg::split_t      split,
    input  wire divergence_pkg::join_res_t   join_res,
    input  wire gpu_types_pkg::wid_t         query_wid,
    output gpu_types_pkg::tmask_t            warp_tmask,
    output gpu_types_pkg::pc_t               warp_pc
);

    import gpu_types_pkg::*;

    tmask_t tmask_r [`NUM_WARPS];
    pc_t    pc_r    [`NUM_WARPS];

    logic split_upd;
    logic join_upd;

    assign split_upd = split.valid && split.is_dvg;
    assign join_upd  = join_res.valid && join_res.is_dvg;

    // A split and a join result in the same cycle always belong to
    // different warps, since commands for one warp are spaced apart
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `NUM_WARPS; i++) begin
                tmask_r[i] <= '1;
                pc_r[i]    <= `RESET_PC;
            end
        end else begin
            if (split_upd) begin
                tmask_r[split_wid] <= split.then_tmask;
            end
            if (join_upd) begin
                tmask_r[join_res.wid] <= join_res.tmask;
                // Only the switch to the else side moves the PC
                if (join_res.is_else) begin
                    pc_r[join_res.wid] <= join_res.pc;
                end
            end
        end
    end

    // Read port for the warp of the current command
    assign rd_tmask = tmask_r[rd_wid];

    // Read port for outside inspection
    assign warp_tmask = tmask_r[query_wid];
    assign warp_pc    = pc_r[query_wid];

endmodule

`default_nettype wire

// File: tb/divergence_unit_tb.sv
// Divergence unit testbench
`default_nettype none

`include "divergence_defs.svh"

module divergence_unit_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import gpu_types_pkg::*;
    import divergence_pkg::*;

    localparam int CLK_PERIOD = 40;

    // One stimulus row with the expected join result and warp state
    typedef struct packed {
        logic   is_split;
        wid_t   wid;
        tmask_t pred;
        pc_t    else_pc;
        sptr_t  join_ptr;
        logic   gap;
        logic   exp_dvg;
        logic   exp_else;
        tmask_t exp_res_tmask;
        pc_t    exp_res_pc;
        tmask_t exp_tmask;
        pc_t    exp_pc;
        sptr_t  exp_sp;
    } row_t;

    logic      clk;
    logic      rst_n;
    cmd_t      cmd;
    wid_t      query_wid;
    wid_t      stack_wid;
    join_res_t join_res;
    tmask_t    warp_tmask;
    pc_t       warp_pc;
    sptr_t     stack_ptr;

    row_t rows[$];
    // Row index per clock slot, -1 marks an idle cycle
    int   schedule[$];
    logic table_ready = 1'b0;
    int   checks = 0;
    int   errors = 0;

    divergence_unit u_divergence_unit (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd        (cmd),
        .query_wid  (query_wid),
        .stack_wid  (stack_wid),
        .join_res   (join_res),
        .warp_tmask (warp_tmask),
        .warp_pc    (warp_pc),
        .stack_ptr  (stack_ptr)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic compare_hex(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic add_split(input wid_t wid, input tmask_t pred, input pc_t else_pc,
                             input logic gap, input tmask_t exp_tmask, input pc_t exp_pc,
                             input sptr_t exp_sp);
        row_t r;
        r = '0;
        r.is_split  = 1'b1;
        r.wid       = wid;
        r.pred      = pred;
        r.else_pc   = else_pc;
        r.gap       = gap;
        r.exp_tmask = exp_tmask;
        r.exp_pc    = exp_pc;
        r.exp_sp    = exp_sp;
        rows.push_back(r);
    endtask

    task automatic add_join(input wid_t wid, input sptr_t join_ptr, input logic gap,
                            input logic exp_dvg, input logic exp_else,
                            input tmask_t exp_res_tmask, input pc_t exp_res_pc,
                            input tmask_t exp_tmask, input pc_t exp_pc, input sptr_t exp_sp);
        row_t r;
        r = '0;
        r.wid           = wid;
        r.join_ptr      = join_ptr;
        r.gap           = gap;
        r.exp_dvg       = exp_dvg;
        r.exp_else      = exp_else;
        r.exp_res_tmask = exp_res_tmask;
        r.exp_res_pc    = exp_res_pc;
        r.exp_tmask     = exp_tmask;
        r.exp_pc        = exp_pc;
        r.exp_sp        = exp_sp;
        rows.push_back(r);
    endtask

    // Expected values follow the split and join rules by hand, warp by warp
    task automatic build_table();
        // Split columns are wid, pred, else_pc, gap, then mask, PC, stack_ptr afterwards
        // Join columns are wid, ptr, gap, is_dvg, is_else, result mask and PC, then state
        add_split(2'd0, 4'hF, 16'h0200, 1'b0, 4'hF, `RESET_PC, 3'd0);
        add_split(2'd3, 4'h0, 16'h0300, 1'b0, 4'hF, `RESET_PC, 3'd0);
        add_join(2'd0, 3'd0, 1'b0, 1'b0, 1'b0, 4'hF, 16'h0000, 4'hF, `RESET_PC, 3'd0);
        add_join(2'd3, 3'd0, 1'b0, 1'b0, 1'b0, 4'hF, 16'h0000, 4'hF, `RESET_PC, 3'd0);

        // Warp 0 splits once, runs the else side, then reconverges
        add_split(2'd0, 4'h3, 16'h0240, 1'b1, 4'h3, `RESET_PC, 3'd1);
        add_join(2'd0, 3'd0, 1'b1, 1'b1, 1'b1, 4'hC, 16'h0240, 4'hC, 16'h0240, 3'd1);
        add_join(2'd0, 3'd0, 1'b0, 1'b1, 1'b0, 4'hF, 16'h0000, 4'hF, 16'h0240, 3'd0);

        // Warp 1 nests two levels, the inner level unwinds first
        add_split(2'd1, 4'h5, 16'h0400, 1'b1, 4'h5, `RESET_PC, 3'd1);
        add_split(2'd1, 4'h1, 16'h0500, 1'b1, 4'h1, `RESET_PC, 3'd2);
        add_join(2'd1, 3'd1, 1'b1, 1'b1, 1'b1, 4'h4, 16'h0500, 4'h4, 16'h0500, 3'd2);
        add_join(2'd1, 3'd1, 1'b1, 1'b1, 1'b0, 4'h5, 16'h0000, 4'h5, 16'h0500, 3'd1);
        add_join(2'd1, 3'd0, 1'b1, 1'b1, 1'b1, 4'hA, 16'h0400, 4'hA, 16'h0400, 3'd1);
        add_join(2'd1, 3'd0, 1'b0, 1'b1, 1'b0, 4'hF, 16'h0000, 4'hF, 16'h0400, 3'd0);

        // Warps 2 and 3 interleave, so two joins are in flight at once
        add_split(2'd2, 4'h8, 16'h0600, 1'b0, 4'h8, `RESET_PC, 3'd1);
        add_split(2'd3, 4'h6, 16'h0700, 1'b0, 4'h6, `RESET_PC, 3'd1);
        add_join(2'd2, 3'd0, 1'b0, 1'b1, 1'b1, 4'h7, 16'h0600, 4'h7, 16'h0600, 3'd1);
        add_join(2'd3, 3'd0, 1'b0, 1'b1, 1'b1, 4'h9, 16'h0700, 4'h9, 16'h0700, 3'd1);
        add_join(2'd2, 3'd0, 1'b0, 1'b1, 1'b0, 4'hF, 16'h0000, 4'hF, 16'h0600, 3'd0);
        add_join(2'd3, 3'd0, 1'b0, 1'b1, 1'b0, 4'hF, 16'h0000, 4'hF, 16'h0700, 3'd0);

        // Warp 0 diverges again and reuses the entry it popped before
        add_split(2'd0, 4'h9, 16'h0800, 1'b1, 4'h9, 16'h0240, 3'd1);
        add_join(2'd0, 3'd0, 1'b1, 1'b1, 1'b1, 4'h6, 16'h0800, 4'h6, 16'h0800, 3'd1);
        add_join(2'd0, 3'd0, 1'b0, 1'b1, 1'b0, 4'hF, 16'h0000, 4'hF, 16'h0800, 3'd0);

        for (int i = 0; i < rows.size(); i++) begin
            schedule.push_back(i);
            if (rows[i].gap) begin
                schedule.push_back(-1);
            end
        end
        // Two idle slots let the last row's checks complete
        schedule.push_back(-1);
        schedule.push_back(-1);
    endtask

    task automatic drive_row(input row_t r);
        cmd_t c;
        c = '0;
        c.valid     = 1'b1;
        c.is_split  = r.is_split;
        c.is_join   = !r.is_split;
        c.wid       = r.wid;
        c.pred      = r.pred;
        c.else_pc   = r.else_pc;
        c.stack_ptr = r.join_ptr;
        cmd <= c;
    endtask

    task automatic check_reset_state();
        for (int w = 0; w < `NUM_WARPS; w++) begin
            @(posedge clk);
            query_wid <= wid_t'(w);
            stack_wid <= wid_t'(w);
            @(negedge clk);
            compare_hex($sformatf("warp_tmask (warp %0d)", w), warp_tmask, 4'hF);
            compare_hex($sformatf("warp_pc (warp %0d)", w), warp_pc, `RESET_PC);
            compare_hex($sformatf("stack_ptr (warp %0d)", w), stack_ptr, 3'd0);
            compare_hex("join_res.valid", join_res.valid, 1'b0);
        end
    endtask

    // Looks at the join result of the command sampled at the last edge
    task automatic check_join_result(input int idx);
        row_t r;
        if (idx < 0) begin
            compare_hex("join_res.valid", join_res.valid, 1'b0);
        end else begin
            r = rows[idx];
            if (r.is_split) begin
                compare_hex($sformatf("join_res.valid (row %0d)", idx), join_res.valid, 1'b0);
            end else begin
                compare_hex($sformatf("join_res.valid (row %0d)", idx), join_res.valid, 1'b1);
                compare_hex($sformatf("join_res.wid (row %0d)", idx), join_res.wid, r.wid);
                compare_hex($sformatf("join_res.is_dvg (row %0d)", idx), join_res.is_dvg,
                            r.exp_dvg);
                compare_hex($sformatf("join_res.is_else (row %0d)", idx), join_res.is_else,
                            r.exp_else);
                compare_hex($sformatf("join_res.tmask (row %0d)", idx), join_res.tmask,
                            r.exp_res_tmask);
                if (r.exp_else) begin
                    compare_hex($sformatf("join_res.pc (row %0d)", idx), join_res.pc,
                                r.exp_res_pc);
                end
            end
        end
    endtask

    task automatic check_warp_state(input int idx);
        row_t r;
        r = rows[idx];
        compare_hex($sformatf("warp_tmask (row %0d)", idx), warp_tmask, r.exp_tmask);
        compare_hex($sformatf("warp_pc (row %0d)", idx), warp_pc, r.exp_pc);
        compare_hex($sformatf("stack_ptr (row %0d)", idx), stack_ptr, r.exp_sp);
    endtask

    initial begin : watchdog
        int limit_cycles;
        wait (table_ready);
        limit_cycles = rows.size() * 3 + 20;
        #(limit_cycles * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles before the table was done", limit_cycles);
        $display("Something failed");
        $finish;
    end

    initial begin
        cmd       = '0;
        query_wid = '0;
        stack_wid = '0;
        rst_n     = 1'b0;
        build_table();
        table_ready = 1'b1;

        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        check_reset_state();

        // Slot k drives its row, checks the result of slot k-1 and the state of slot k-2
        for (int k = 0; k < schedule.size(); k++) begin
            @(posedge clk);
            if (schedule[k] >= 0) begin
                drive_row(rows[schedule[k]]);
            end else begin
                cmd <= '0;
            end
            if (k >= 2 && schedule[k-2] >= 0) begin
                query_wid <= rows[schedule[k-2]].wid;
                stack_wid <= rows[schedule[k-2]].wid;
            end
            @(negedge clk);
            if (k >= 1) begin
                check_join_result(schedule[k-1]);
            end
            if (k >= 2 && schedule[k-2] >= 0) begin
                check_warp_state(schedule[k-2]);
            end
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
